// ==== hw/tile_memsys_pkg.sv ====
// Tile memory subsystem definitions
`default_nettype none

package tile_memsys_pkg;

   // Bus widths
   localparam int ADDR_WIDTH = 16;
   localparam int DATA_WIDTH = 32;
   localparam int SEL_WIDTH  = DATA_WIDTH / 8;

   // Byte offset bits inside one word
   localparam int ADDR_LSB = $clog2(SEL_WIDTH);

   // RAM defaults, 4 KiB behind the bridge
   localparam int MEM_WORDS = 1024;
   localparam int RAM_WAIT  = 3;

   // Byte address
   typedef logic [ADDR_WIDTH-1:0] addr_t;

   // Data word and its byte enables
   typedef logic [DATA_WIDTH-1:0] word_t;
   typedef logic [SEL_WIDTH-1:0]  sel_t;

   // AXI response codes, only the two the RAM can return
   typedef logic [1:0] resp_t;

   localparam resp_t RESP_OKAY   = 2'b00;
   localparam resp_t RESP_DECERR = 2'b11;

endpackage

`default_nettype wire

// ==== hw/dbg_cmd_master.sv ====
// Debug command master
`timescale 1ns/10ps
`default_nettype none

module dbg_cmd_master (
   input  wire logic                   clk,
   input  wire logic                   rst_n_i,

   // Host command port
   input  wire logic                   cmd_valid_i,
   input  wire logic                   cmd_we_i,
   input  wire tile_memsys_pkg::addr_t cmd_addr_i,
   input  wire tile_memsys_pkg::sel_t  cmd_sel_i,
   input  wire tile_memsys_pkg::word_t cmd_wdata_i,
   output logic                        rsp_valid_o,
   output tile_memsys_pkg::word_t      rsp_rdata_o,
   output logic                        rsp_err_o,

   // Wishbone classic master
   output logic                        wb_cyc_o,
   output logic                        wb_stb_o,
   output logic                        wb_we_o,
   output tile_memsys_pkg::addr_t      wb_adr_o,
   output tile_memsys_pkg::sel_t       wb_sel_o,
   output tile_memsys_pkg::word_t      wb_dat_o,
   input  wire logic                   wb_ack_i,
   input  wire logic                   wb_err_i,
   input  wire tile_memsys_pkg::word_t wb_dat_i
);

   typedef enum logic {
      ST_IDLE,
      ST_BUS
   } state_t;

   state_t state_q;
   logic   cmd_take;
   logic   bus_done;

   assign cmd_take = (state_q == ST_IDLE) && cmd_valid_i;

   // Slave terminated the cycle with ack or err
   assign bus_done = (state_q == ST_BUS) && (wb_ack_i || wb_err_i);

   // Single outstanding cycle, so cyc and stb move together
   assign wb_cyc_o = (state_q == ST_BUS);
   assign wb_stb_o = (state_q == ST_BUS);

   always_ff @(posedge clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         state_q     <= ST_IDLE;
         rsp_valid_o <= 1'b0;
         rsp_err_o   <= 1'b0;
      end else begin
         rsp_valid_o <= bus_done;
         case (state_q)
            ST_IDLE: begin
               if (cmd_valid_i) begin
                  state_q <= ST_BUS;
               end
            end
            ST_BUS: begin
               if (bus_done) begin
                  state_q   <= ST_IDLE;
                  rsp_err_o <= wb_err_i;
               end
            end
            default: begin
               state_q <= ST_IDLE;
            end
         endcase
      end
   end

   // Command fields held for the whole bus cycle
   always_ff @(posedge clk) begin
      if (cmd_take) begin
         wb_we_o  <= cmd_we_i;
         wb_adr_o <= cmd_addr_i;
         wb_sel_o <= cmd_sel_i;
         wb_dat_o <= cmd_wdata_i;
      end
      // Error responses carry no data
      if (bus_done) begin
         rsp_rdata_o <= wb_ack_i ? wb_dat_i : '0;
      end
   end

   // Host waits for the response before the next command
   a_no_cmd_while_busy: assert property (
      @(posedge clk) disable iff (!rst_n_i)
      cmd_valid_i |-> (state_q == ST_IDLE)
   );

   a_ack_err_exclusive: assert property (
      @(posedge clk) disable iff (!rst_n_i)
      wb_cyc_o |-> !(wb_ack_i && wb_err_i)
   );

endmodule

`default_nettype wire

// ==== hw/wb2axi.sv ====
// Wishbone to AXI bridge
`timescale 1ns/10ps
`default_nettype none

module wb2axi (
   input  wire logic                   clk,
   input  wire logic                   rst_n_i,

   // Wishbone classic slave
   input  wire logic                   wb_cyc_i,
   input  wire logic                   wb_stb_i,
   input  wire logic                   wb_we_i,
   input  wire tile_memsys_pkg::addr_t wb_adr_i,
   input  wire tile_memsys_pkg::sel_t  wb_sel_i,
   input  wire tile_memsys_pkg::word_t wb_dat_i,
   output logic                        wb_ack_o,
   output logic                        wb_err_o,
   output tile_memsys_pkg::word_t      wb_dat_o,

   // AXI write channels
   output logic                        aw_valid_o,
   input  wire logic                   aw_ready_i,
   output tile_memsys_pkg::addr_t      aw_addr_o,
   output logic                        w_valid_o,
   input  wire logic                   w_ready_i,
   output tile_memsys_pkg::word_t      w_data_o,
   output tile_memsys_pkg::sel_t       w_strb_o,
   input  wire logic                   b_valid_i,
   output logic                        b_ready_o,
   input  wire tile_memsys_pkg::resp_t b_resp_i,

   // AXI read channels
   output logic                        ar_valid_o,
   input  wire logic                   ar_ready_i,
   output tile_memsys_pkg::addr_t      ar_addr_o,
   input  wire logic                   r_valid_i,
   output logic                        r_ready_o,
   input  wire tile_memsys_pkg::word_t r_data_i,
   input  wire tile_memsys_pkg::resp_t r_resp_i
);

   typedef enum logic [1:0] {
      ST_IDLE,
      ST_ADDR,
      ST_RESP,
      ST_DONE
   } state_t;

   state_t                 state_q;
   logic                   we_q;
   logic                   resp_ok_q;
   tile_memsys_pkg::addr_t addr_q;
   logic                   aw_left;
   logic                   w_left;
   logic                   ar_left;
   logic                   rsp_hs;

   // Channels still waiting for their ready after this edge
   assign aw_left = aw_valid_o && !aw_ready_i;
   assign w_left  = w_valid_o && !w_ready_i;
   assign ar_left = ar_valid_o && !ar_ready_i;

   assign b_ready_o = (state_q == ST_RESP) && we_q;
   assign r_ready_o = (state_q == ST_RESP) && !we_q;
   assign rsp_hs    = (b_valid_i && b_ready_o) || (r_valid_i && r_ready_o);

   // One-cycle termination in the done state
   assign wb_ack_o = (state_q == ST_DONE) && resp_ok_q;
   assign wb_err_o = (state_q == ST_DONE) && !resp_ok_q;

   assign aw_addr_o = addr_q;
   assign ar_addr_o = addr_q;

   always_ff @(posedge clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         state_q    <= ST_IDLE;
         we_q       <= 1'b0;
         resp_ok_q  <= 1'b0;
         aw_valid_o <= 1'b0;
         w_valid_o  <= 1'b0;
         ar_valid_o <= 1'b0;
      end else begin
         case (state_q)
            ST_IDLE: begin
               if (wb_cyc_i && wb_stb_i) begin
                  we_q       <= wb_we_i;
                  aw_valid_o <= wb_we_i;
                  w_valid_o  <= wb_we_i;
                  ar_valid_o <= !wb_we_i;
                  state_q    <= ST_ADDR;
               end
            end
            ST_ADDR: begin
               // AW and W may be taken on different edges
               aw_valid_o <= aw_left;
               w_valid_o  <= w_left;
               ar_valid_o <= ar_left;
               if (!aw_left && !w_left && !ar_left) begin
                  state_q <= ST_RESP;
               end
            end
            ST_RESP: begin
               if (rsp_hs) begin
                  resp_ok_q <= we_q ? (b_resp_i == tile_memsys_pkg::RESP_OKAY)
                                    : (r_resp_i == tile_memsys_pkg::RESP_OKAY);
                  state_q   <= ST_DONE;
               end
            end
            ST_DONE: begin
               // Master drops stb on this edge
               state_q <= ST_IDLE;
            end
            default: begin
               state_q <= ST_IDLE;
            end
         endcase
      end
   end

   // Word-aligned address and write payload
   always_ff @(posedge clk) begin
      if ((state_q == ST_IDLE) && wb_cyc_i && wb_stb_i) begin
         addr_q   <= {wb_adr_i[tile_memsys_pkg::ADDR_WIDTH-1:tile_memsys_pkg::ADDR_LSB],
                      {tile_memsys_pkg::ADDR_LSB{1'b0}}};
         w_data_o <= wb_dat_i;
         w_strb_o <= wb_sel_i;
      end
      if (r_valid_i && r_ready_o) begin
         wb_dat_o <= r_data_i;
      end
   end

   a_aw_stable: assert property (
      @(posedge clk) disable iff (!rst_n_i)
      (aw_valid_o && !aw_ready_i) |=> (aw_valid_o && $stable(aw_addr_o))
   );

   a_ack_single: assert property (
      @(posedge clk) disable iff (!rst_n_i)
      wb_ack_o |=> !wb_ack_o
   );

   a_err_single: assert property (
      @(posedge clk) disable iff (!rst_n_i)
      wb_err_o |=> !wb_err_o
   );

endmodule

`default_nettype wire

// ==== hw/axi_ram.sv ====
// AXI word RAM model
`timescale 1ns/10ps
`default_nettype none

module axi_ram #(
   parameter int DEPTH = tile_memsys_pkg::MEM_WORDS,
   parameter int WAIT  = tile_memsys_pkg::RAM_WAIT
) (
   input  wire logic                   clk,
   input  wire logic                   rst_n_i,

   // Write channels
   input  wire logic                   aw_valid_i,
   output logic                        aw_ready_o,
   input  wire tile_memsys_pkg::addr_t aw_addr_i,
   input  wire logic                   w_valid_i,
   output logic                        w_ready_o,
   input  wire tile_memsys_pkg::word_t w_data_i,
   input  wire tile_memsys_pkg::sel_t  w_strb_i,
   output logic                        b_valid_o,
   input  wire logic                   b_ready_i,
   output tile_memsys_pkg::resp_t      b_resp_o,

   // Read channels
   input  wire logic                   ar_valid_i,
   output logic                        ar_ready_o,
   input  wire tile_memsys_pkg::addr_t ar_addr_i,
   output logic                        r_valid_o,
   input  wire logic                   r_ready_i,
   output tile_memsys_pkg::word_t      r_data_o,
   output tile_memsys_pkg::resp_t      r_resp_o
);

   localparam int IDX_W  = (DEPTH > 1) ? $clog2(DEPTH) : 1;
   localparam int CNT_W  = (WAIT > 0) ? $clog2(WAIT + 1) : 1;
   localparam int WORD_W = tile_memsys_pkg::ADDR_WIDTH - tile_memsys_pkg::ADDR_LSB;

   typedef enum logic [1:0] {
      ST_IDLE,
      ST_WAIT,
      ST_RESP
   } state_t;

   state_t                 state_q;
   logic [CNT_W-1:0]       cnt_q;
   logic                   is_wr_q;
   tile_memsys_pkg::resp_t resp_q;
   tile_memsys_pkg::word_t mem [DEPTH];
   logic [WORD_W-1:0]      aw_word;
   logic [WORD_W-1:0]      ar_word;
   logic                   wr_hs;
   logic                   rd_hs;
   logic                   wr_hit;
   logic                   rd_hit;

   assign aw_word = aw_addr_i[tile_memsys_pkg::ADDR_WIDTH-1:tile_memsys_pkg::ADDR_LSB];
   assign ar_word = ar_addr_i[tile_memsys_pkg::ADDR_WIDTH-1:tile_memsys_pkg::ADDR_LSB];
   assign wr_hit  = (aw_word < DEPTH);
   assign rd_hit  = (ar_word < DEPTH);

   // Accept only when idle; a write wins over a read
   assign wr_hs      = (state_q == ST_IDLE) && aw_valid_i && w_valid_i;
   assign rd_hs      = (state_q == ST_IDLE) && ar_valid_i && !wr_hs;
   assign aw_ready_o = wr_hs;
   assign w_ready_o  = wr_hs;
   assign ar_ready_o = rd_hs;

   assign b_valid_o = (state_q == ST_RESP) && is_wr_q;
   assign r_valid_o = (state_q == ST_RESP) && !is_wr_q;
   assign b_resp_o  = resp_q;
   assign r_resp_o  = resp_q;

   always_ff @(posedge clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         state_q <= ST_IDLE;
         cnt_q   <= '0;
         is_wr_q <= 1'b0;
      end else begin
         case (state_q)
            ST_IDLE: begin
               if (wr_hs || rd_hs) begin
                  is_wr_q <= wr_hs;
                  cnt_q   <= CNT_W'(WAIT);
                  state_q <= (WAIT == 0) ? ST_RESP : ST_WAIT;
               end
            end
            ST_WAIT: begin
               cnt_q <= cnt_q - 1'b1;
               if (cnt_q == CNT_W'(1)) begin
                  state_q <= ST_RESP;
               end
            end
            ST_RESP: begin
               if ((b_valid_o && b_ready_i) || (r_valid_o && r_ready_i)) begin
                  state_q <= ST_IDLE;
               end
            end
            default: begin
               state_q <= ST_IDLE;
            end
         endcase
      end
   end

   // Storage, read data and response code
   always_ff @(posedge clk) begin
      if (wr_hs && wr_hit) begin
         for (int i = 0; i < tile_memsys_pkg::SEL_WIDTH; i++) begin
            if (w_strb_i[i]) begin
               mem[aw_word[IDX_W-1:0]][8*i +: 8] <= w_data_i[8*i +: 8];
            end
         end
      end
      if (wr_hs) begin
         resp_q <= wr_hit ? tile_memsys_pkg::RESP_OKAY : tile_memsys_pkg::RESP_DECERR;
      end else if (rd_hs) begin
         resp_q   <= rd_hit ? tile_memsys_pkg::RESP_OKAY : tile_memsys_pkg::RESP_DECERR;
         // Out of range reads return zero
         r_data_o <= rd_hit ? mem[ar_word[IDX_W-1:0]] : '0;
      end
   end

   a_b_hold: assert property (
      @(posedge clk) disable iff (!rst_n_i)
      (b_valid_o && !b_ready_i) |=> (b_valid_o && $stable(b_resp_o))
   );

   a_r_hold: assert property (
      @(posedge clk) disable iff (!rst_n_i)
      (r_valid_o && !r_ready_i) |=> (r_valid_o && $stable(r_data_o))
   );

endmodule

`default_nettype wire

// ==== hw/tile_memsys_top.sv ====
// Tile memory subsystem top
`timescale 1ns/10ps
`default_nettype none

module tile_memsys_top (
   input  wire logic                   clk,
   input  wire logic                   rst_n_i,

   // Host command and response ports
   input  wire logic                   cmd_valid_i,
   input  wire logic                   cmd_we_i,
   input  wire tile_memsys_pkg::addr_t cmd_addr_i,
   input  wire tile_memsys_pkg::sel_t  cmd_sel_i,
   input  wire tile_memsys_pkg::word_t cmd_wdata_i,
   output logic                        rsp_valid_o,
   output tile_memsys_pkg::word_t      rsp_rdata_o,
   output logic                        rsp_err_o
);

   // Wishbone between command master and bridge
   logic                   wb_cyc;
   logic                   wb_stb;
   logic                   wb_we;
   tile_memsys_pkg::addr_t wb_adr;
   tile_memsys_pkg::sel_t  wb_sel;
   tile_memsys_pkg::word_t wb_dat_w;
   logic                   wb_ack;
   logic                   wb_err;
   tile_memsys_pkg::word_t wb_dat_r;

   // AXI between bridge and RAM
   logic                   aw_valid;
   logic                   aw_ready;
   tile_memsys_pkg::addr_t aw_addr;
   logic                   w_valid;
   logic                   w_ready;
   tile_memsys_pkg::word_t w_data;
   tile_memsys_pkg::sel_t  w_strb;
   logic                   b_valid;
   logic                   b_ready;
   tile_memsys_pkg::resp_t b_resp;
   logic                   ar_valid;
   logic                   ar_ready;
   tile_memsys_pkg::addr_t ar_addr;
   logic                   r_valid;
   logic                   r_ready;
   tile_memsys_pkg::word_t r_data;
   tile_memsys_pkg::resp_t r_resp;

   dbg_cmd_master u_dbg_cmd_master (
      .clk         (clk),
      .rst_n_i     (rst_n_i),
      .cmd_valid_i (cmd_valid_i),
      .cmd_we_i    (cmd_we_i),
      .cmd_addr_i  (cmd_addr_i),
      .cmd_sel_i   (cmd_sel_i),
      .cmd_wdata_i (cmd_wdata_i),
      .rsp_valid_o (rsp_valid_o),
      .rsp_rdata_o (rsp_rdata_o),
      .rsp_err_o   (rsp_err_o),
      .wb_cyc_o    (wb_cyc),
      .wb_stb_o    (wb_stb),
      .wb_we_o     (wb_we),
      .wb_adr_o    (wb_adr),
      .wb_sel_o    (wb_sel),
      .wb_dat_o    (wb_dat_w),
      .wb_ack_i    (wb_ack),
      .wb_err_i    (wb_err),
      .wb_dat_i    (wb_dat_r)
   );

   // Single-beat bridge towards the DRAM stand-in
   wb2axi u_wb2axi (
      .clk        (clk),
      .rst_n_i    (rst_n_i),
      .wb_cyc_i   (wb_cyc),
      .wb_stb_i   (wb_stb),
      .wb_we_i    (wb_we),
      .wb_adr_i   (wb_adr),
      .wb_sel_i   (wb_sel),
      .wb_dat_i   (wb_dat_w),
      .wb_ack_o   (wb_ack),
      .wb_err_o   (wb_err),
      .wb_dat_o   (wb_dat_r),
      .aw_valid_o (aw_valid),
      .aw_ready_i (aw_ready),
      .aw_addr_o  (aw_addr),
      .w_valid_o  (w_valid),
      .w_ready_i  (w_ready),
      .w_data_o   (w_data),
      .w_strb_o   (w_strb),
      .b_valid_i  (b_valid),
      .b_ready_o  (b_ready),
      .b_resp_i   (b_resp),
      .ar_valid_o (ar_valid),
      .ar_ready_i (ar_ready),
      .ar_addr_o  (ar_addr),
      .r_valid_i  (r_valid),
      .r_ready_o  (r_ready),
      .r_data_i   (r_data),
      .r_resp_i   (r_resp)
   );

   axi_ram u_axi_ram (
      .clk        (clk),
      .rst_n_i    (rst_n_i),
      .aw_valid_i (aw_valid),
      .aw_ready_o (aw_ready),
      .aw_addr_i  (aw_addr),
      .w_valid_i  (w_valid),
      .w_ready_o  (w_ready),
      .w_data_i   (w_data),
      .w_strb_i   (w_strb),
      .b_valid_o  (b_valid),
      .b_ready_i  (b_ready),
      .b_resp_o   (b_resp),
      .ar_valid_i (ar_valid),
      .ar_ready_o (ar_ready),
      .ar_addr_i  (ar_addr),
      .r_valid_o  (r_valid),
      .r_ready_i  (r_ready),
      .r_data_o   (r_data),
      .r_resp_o   (r_resp)
   );

endmodule

`default_nettype wire

// ==== verif/tile_memsys_tb.sv ====
// Tile memory subsystem testbench
`timescale 1ns/10ps
`default_nettype none

module tile_memsys_tb;

   localparam int CLK_PERIOD  = 10;
   localparam int RST_CYCLES  = 10;
   localparam int RSP_LIMIT   = 64;
   localparam int N_TABLE     = 13;
   localparam int N_FILL      = 16;
   localparam int N_CMDS      = N_TABLE + 2 * N_FILL;
   localparam int WATCHDOG_NS = N_CMDS * RSP_LIMIT * CLK_PERIOD + RST_CYCLES * CLK_PERIOD;

   localparam logic [31:0] LFSR_SEED = 32'd73043;
   localparam logic [31:0] LFSR_MASK = 32'h8020_0003;

   // 0x11223344 after lanes 0 and 2 are written with 0xAABBCCDD
   localparam tile_memsys_pkg::word_t MERGED_WORD = 32'h11BB_33DD;

   typedef struct packed {
      logic                   we;
      tile_memsys_pkg::addr_t addr;
      tile_memsys_pkg::sel_t  sel;
      tile_memsys_pkg::word_t wdata;
      tile_memsys_pkg::word_t exp_rdata;
      logic                   exp_err;
   } cmd_entry_t;

   logic                   clk;
   logic                   rst_n_i;
   logic                   cmd_valid_i;
   logic                   cmd_we_i;
   tile_memsys_pkg::addr_t cmd_addr_i;
   tile_memsys_pkg::sel_t  cmd_sel_i;
   tile_memsys_pkg::word_t cmd_wdata_i;
   logic                   rsp_valid_o;
   tile_memsys_pkg::word_t rsp_rdata_o;
   logic                   rsp_err_o;

   cmd_entry_t             cmd_table [N_TABLE];
   tile_memsys_pkg::word_t fill_data [N_FILL];
   logic [31:0]            lfsr_q;
   int                     cmd_count;
   int                     rsp_count;

   tile_memsys_top u_tile_memsys_top (
      .clk         (clk),
      .rst_n_i     (rst_n_i),
      .cmd_valid_i (cmd_valid_i),
      .cmd_we_i    (cmd_we_i),
      .cmd_addr_i  (cmd_addr_i),
      .cmd_sel_i   (cmd_sel_i),
      .cmd_wdata_i (cmd_wdata_i),
      .rsp_valid_o (rsp_valid_o),
      .rsp_rdata_o (rsp_rdata_o),
      .rsp_err_o   (rsp_err_o)
   );

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   // Count every response strobe including those in reset
   always @(negedge clk) begin
      if (rsp_valid_o === 1'b1) begin
         rsp_count++;
      end
   end

   function automatic logic [31:0] lfsr_next(input logic [31:0] state);
      return state[0] ? ((state >> 1) ^ LFSR_MASK) : (state >> 1);
   endfunction

   // One LFSR step per data bit
   task automatic next_random_word(output tile_memsys_pkg::word_t w);
      w = '0;
      for (int b = 0; b < tile_memsys_pkg::DATA_WIDTH; b++) begin
         w      = {w[tile_memsys_pkg::DATA_WIDTH-2:0], lfsr_q[0]};
         lfsr_q = lfsr_next(lfsr_q);
      end
   endtask

   task automatic stop_on_error();
      $display("Test failures found");
      $fatal(1, "Stopped at the first error");
   endtask

   task automatic check_data(
      input tile_memsys_pkg::word_t got,
      input tile_memsys_pkg::word_t exp,
      input string                  what
   );
      if (got !== exp) begin
         $display("** Error at %0t ns: %s data %h, expected %h", $time, what, got, exp);
         stop_on_error();
      end
   endtask

   task automatic check_err(input logic got, input logic exp, input string what);
      if (got !== exp) begin
         $display("** Error at %0t ns: %s is %b, expected %b", $time, what, got, exp);
         stop_on_error();
      end
   endtask

   task automatic check_count(input int got, input int exp, input string what);
      if (got != exp) begin
         $display("** Error at %0t ns: %s count %0d, expected %0d", $time, what, got, exp);
         stop_on_error();
      end
   endtask

   task automatic set_entry(
      input int                     idx,
      input logic                   we,
      input tile_memsys_pkg::addr_t addr,
      input tile_memsys_pkg::sel_t  sel,
      input tile_memsys_pkg::word_t wdata,
      input tile_memsys_pkg::word_t exp_rdata,
      input logic                   exp_err
   );
      cmd_table[idx] = '{we, addr, sel, wdata, exp_rdata, exp_err};
   endtask

   task automatic build_table();
      set_entry(0, 1'b1, 16'h0010, 4'hF, 32'h1122_3344, 32'h0, 1'b0);
      set_entry(1, 1'b0, 16'h0010, 4'hF, 32'h0, 32'h1122_3344, 1'b0);
      // Lanes 0 and 2 only
      set_entry(2, 1'b1, 16'h0010, 4'b0101, 32'hAABB_CCDD, 32'h0, 1'b0);
      set_entry(3, 1'b0, 16'h0010, 4'hF, 32'h0, MERGED_WORD, 1'b0);
      set_entry(4, 1'b0, 16'h0013, 4'hF, 32'h0, MERGED_WORD, 1'b0);
      set_entry(5, 1'b1, 16'h0FFC, 4'hF, 32'h5A5A_C3C3, 32'h0, 1'b0);
      set_entry(6, 1'b0, 16'h0FFD, 4'hF, 32'h0, 32'h5A5A_C3C3, 1'b0);
      // Without the decode 0x1010 would alias word 4
      set_entry(7, 1'b1, 16'h1000, 4'hF, 32'hDEAD_BEEF, 32'h0, 1'b1);
      set_entry(8, 1'b1, 16'h1010, 4'hF, 32'hDEAD_BEEF, 32'h0, 1'b1);
      set_entry(9, 1'b0, 16'h1000, 4'hF, 32'h0, 32'h0, 1'b1);
      set_entry(10, 1'b0, 16'hFFFC, 4'hF, 32'h0, 32'h0, 1'b1);
      set_entry(11, 1'b0, 16'h0010, 4'hF, 32'h0, MERGED_WORD, 1'b0);
      set_entry(12, 1'b0, 16'h0FFC, 4'hF, 32'h0, 32'h5A5A_C3C3, 1'b0);
   endtask

   // Issue one command and wait for its response strobe
   task automatic run_cmd(
      input  logic                   we,
      input  tile_memsys_pkg::addr_t addr,
      input  tile_memsys_pkg::sel_t  sel,
      input  tile_memsys_pkg::word_t wdata,
      output tile_memsys_pkg::word_t rdata,
      output logic                   err
   );
      int   waited;
      logic seen;
      @(posedge clk);
      #1;
      cmd_valid_i = 1'b1;
      cmd_we_i    = we;
      cmd_addr_i  = addr;
      cmd_sel_i   = sel;
      cmd_wdata_i = wdata;
      cmd_count++;
      @(posedge clk);
      #1;
      cmd_valid_i = 1'b0;
      seen   = 1'b0;
      waited = 0;
      rdata  = '0;
      err    = 1'b0;
      while (!seen && waited < RSP_LIMIT) begin
         @(negedge clk);
         waited++;
         if (rsp_valid_o === 1'b1) begin
            seen  = 1'b1;
            rdata = rsp_rdata_o;
            err   = rsp_err_o;
         end
      end
      if (!seen) begin
         $display("Command %0d got no response within %0d cycles", cmd_count, RSP_LIMIT);
         stop_on_error();
      end
      // Strobe must be gone one cycle later
      @(negedge clk);
      check_err(rsp_valid_o, 1'b0, "rsp_valid_o one cycle after response");
      check_count(rsp_count, cmd_count, "response pulse");
   endtask

   task automatic apply_entry(input int idx);
      tile_memsys_pkg::word_t rdata;
      logic                   err;
      cmd_entry_t             e;
      e = cmd_table[idx];
      run_cmd(e.we, e.addr, e.sel, e.wdata, rdata, err);
      check_err(err, e.exp_err, $sformatf("entry %0d rsp_err_o", idx));
      // A write returns defined data only with an error
      if (!e.we || e.exp_err) begin
         check_data(rdata, e.exp_rdata, $sformatf("entry %0d read", idx));
      end
   endtask

   initial begin
      #(WATCHDOG_NS);
      $display("Run timed out after %0d ns before the tests finished", WATCHDOG_NS);
      stop_on_error();
   end

   initial begin
      tile_memsys_pkg::word_t rdata;
      tile_memsys_pkg::word_t w;
      tile_memsys_pkg::addr_t addr;
      logic                   err;
      rst_n_i     = 1'b0;
      cmd_valid_i = 1'b0;
      cmd_we_i    = 1'b0;
      cmd_addr_i  = '0;
      cmd_sel_i   = '0;
      cmd_wdata_i = '0;
      lfsr_q      = LFSR_SEED;
      cmd_count   = 0;
      rsp_count   = 0;
      build_table();
      repeat (RST_CYCLES) @(posedge clk);
      #1;
      rst_n_i = 1'b1;
      repeat (3) @(negedge clk);
      #1;
      check_count(rsp_count, 0, "response pulses around reset");

      for (int i = 0; i < N_TABLE; i++) begin
         apply_entry(i);
      end

      // All spread words written before any read back
      for (int i = 0; i < N_FILL; i++) begin
         addr = tile_memsys_pkg::addr_t'(i * 'h104 + 'h20);
         next_random_word(w);
         fill_data[i] = w;
         run_cmd(1'b1, addr, 4'hF, w, rdata, err);
         check_err(err, 1'b0, $sformatf("fill write %0d rsp_err_o", i));
      end
      for (int i = 0; i < N_FILL; i++) begin
         addr = tile_memsys_pkg::addr_t'(i * 'h104 + 'h20);
         run_cmd(1'b0, addr, 4'hF, '0, rdata, err);
         check_err(err, 1'b0, $sformatf("fill read %0d rsp_err_o", i));
         check_data(rdata, fill_data[i], $sformatf("fill read %0d", i));
      end

      $display("All tests passed!");
      $finish;
   end

endmodule

`default_nettype wire

// ==== tile_memsys.f ====
hw/tile_memsys_pkg.sv
hw/dbg_cmd_master.sv
hw/wb2axi.sv
hw/axi_ram.sv
hw/tile_memsys_top.sv
verif/tile_memsys_tb.sv

// ==== Makefile ====
# Verilator flow for the tile memory subsystem

VERILATOR ?= verilator
TB_TOP    ?= tile_memsys_tb
RTL_TOP   ?= tile_memsys_top
FILELIST  ?= tile_memsys.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only --timing -Wall
PASS_MSG  ?= All tests passed!

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TB_TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Pass or fail comes from the simulation output
run: build
	@out="$$(./$(OBJ_DIR)/V$(TB_TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
